// ==== source/cl_ocl_pkg.sv ====
`default_nettype none

package cl_ocl_pkg;

   // ------------------------------
   // Configuration bus
   // ------------------------------

   // Request from the slave to one test block
   typedef struct packed {
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [3:0]  wstrb;
      logic        wr;       // One clock pulse
      logic        rd;       // One clock pulse
   } cfg_req_t;

   // Answer from a block, also used for the merged completion
   typedef struct packed {
      logic        ack;
      logic [31:0] rdata;
   } cfg_rsp_t;

   // ------------------------------
   // AXI-Lite response codes
   // ------------------------------

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_DECERR = 2'b11
   } axi_resp_t;

   // Block select field, 256B per block
   localparam int SEL_LSB   = 8;
   localparam int SEL_WIDTH = 8;

   // Register word index on addr[3:2]
   localparam logic [1:0] REG_SCRATCH = 2'd0;
   localparam logic [1:0] REG_ID      = 2'd1;
   localparam logic [1:0] REG_WR_CNT  = 2'd2;
   // Index 3 reads zero

endpackage

`default_nettype wire

// ==== source/cl_ocl_slv.sv ====
`timescale 1ns/1ps
`default_nettype none

module cl_ocl_slv #(
   parameter int NUM_TST = 4
) (
   input  logic                 clk,
   input  logic                 sync_rst_n,

   input  logic [31:0]          sh_ocl_awaddr,
   input  logic                 sh_ocl_awvalid,
   output logic                 ocl_sh_awready,

   input  logic [31:0]          sh_ocl_wdata,
   input  logic [3:0]           sh_ocl_wstrb,
   input  logic                 sh_ocl_wvalid,
   output logic                 ocl_sh_wready,

   output logic [1:0]           ocl_sh_bresp,
   output logic                 ocl_sh_bvalid,
   input  logic                 sh_ocl_bready,

   input  logic [31:0]          sh_ocl_araddr,
   input  logic                 sh_ocl_arvalid,
   output logic                 ocl_sh_arready,

   output logic [31:0]          ocl_sh_rdata,
   output logic [1:0]           ocl_sh_rresp,
   output logic                 ocl_sh_rvalid,
   input  logic                 sh_ocl_rready,

   output cl_ocl_pkg::cfg_req_t tst_req [NUM_TST],
   input  cl_ocl_pkg::cfg_rsp_t tst_done
);

   import cl_ocl_pkg::*;

   typedef enum logic [1:0] {
      SLV_IDLE    = 2'd0,
      SLV_WR_ADDR = 2'd1,
      SLV_CYC     = 2'd2,
      SLV_RESP    = 2'd3
   } slv_state_t;

   slv_state_t slv_state, slv_state_nxt;

   logic                 slv_cyc_wr;     // Winner of arbitration is a write
   logic [31:0]          slv_addr;
   logic [SEL_WIDTH-1:0] slv_sel;
   logic                 slv_sel_hit;    // Select maps to a block
   logic                 slv_req_valid;
   logic                 slv_rsp_ready;
   logic                 slv_did_req;
   logic                 slv_issue;
   logic                 slv_cyc_done;
   logic [31:0]          slv_rdata;
   axi_resp_t            slv_resp;

   assign slv_sel       = slv_addr[SEL_LSB +: SEL_WIDTH];
   assign slv_sel_hit   = (32'(slv_sel) < NUM_TST);
   assign slv_req_valid = slv_cyc_wr ? sh_ocl_wvalid : 1'b1;
   assign slv_rsp_ready = slv_cyc_wr ? sh_ocl_bready : sh_ocl_rready;

   // One pulse per transaction
   assign slv_issue = (slv_state == SLV_CYC) && slv_req_valid && !slv_did_req && slv_sel_hit;

   // Unmapped select completes internally
   assign slv_cyc_done = (slv_state == SLV_CYC) &&
                         (slv_sel_hit ? tst_done.ack : slv_req_valid);

   // ------------------------------
   // State machine
   // ------------------------------

   always_comb
   begin
      slv_state_nxt = slv_state;
      case (slv_state)
         SLV_IDLE:
         begin
            if (sh_ocl_awvalid)              // Writes first
               slv_state_nxt = SLV_WR_ADDR;
            else if (sh_ocl_arvalid)
               slv_state_nxt = SLV_CYC;
         end
         SLV_WR_ADDR:
            slv_state_nxt = SLV_CYC;
         SLV_CYC:
         begin
            if (slv_cyc_done)
               slv_state_nxt = SLV_RESP;
         end
         SLV_RESP:
         begin
            if (slv_rsp_ready)
               slv_state_nxt = SLV_IDLE;
         end
         default:
            slv_state_nxt = SLV_IDLE;
      endcase
   end

   always_ff @(posedge clk)
      if (!sync_rst_n)
         slv_state <= SLV_IDLE;
      else
         slv_state <= slv_state_nxt;

   // Address and direction captured at start of transaction
   always_ff @(posedge clk)
      if (!sync_rst_n)
      begin
         slv_addr   <= '0;
         slv_cyc_wr <= 1'b0;
      end
      else if ((slv_state == SLV_IDLE) && (sh_ocl_awvalid || sh_ocl_arvalid))
      begin
         slv_addr   <= sh_ocl_awvalid ? sh_ocl_awaddr : sh_ocl_araddr;
         slv_cyc_wr <= sh_ocl_awvalid;
      end

   always_ff @(posedge clk)
      if (!sync_rst_n)
         slv_did_req <= 1'b0;
      else if (slv_state == SLV_IDLE)
         slv_did_req <= 1'b0;
      else if (slv_issue)
         slv_did_req <= 1'b1;

   // ------------------------------
   // Request fan-out
   // ------------------------------

   // Replicated copy per block for timing
   always_ff @(posedge clk)
      if (!sync_rst_n)
      begin
         for (int i = 0; i < NUM_TST; i++)
            tst_req[i] <= '0;
      end
      else
      begin
         for (int i = 0; i < NUM_TST; i++)
         begin
            tst_req[i].addr  <= slv_addr;
            tst_req[i].wdata <= sh_ocl_wdata;
            tst_req[i].wstrb <= sh_ocl_wstrb;
            tst_req[i].wr    <= slv_issue &&  slv_cyc_wr && (slv_sel == SEL_WIDTH'(i));
            tst_req[i].rd    <= slv_issue && !slv_cyc_wr && (slv_sel == SEL_WIDTH'(i));
         end
      end

   // Completion data and response code
   always_ff @(posedge clk)
      if (!sync_rst_n)
      begin
         slv_rdata <= '0;
         slv_resp  <= RESP_OKAY;
      end
      else if (slv_cyc_done)
      begin
         slv_rdata <= slv_sel_hit ? tst_done.rdata : '0;
         slv_resp  <= slv_sel_hit ? RESP_OKAY : RESP_DECERR;
      end

   // ------------------------------
   // AXI-Lite handshakes
   // ------------------------------

   always_ff @(posedge clk)
      if (!sync_rst_n)
      begin
         ocl_sh_awready <= 1'b0;
         ocl_sh_wready  <= 1'b0;
         ocl_sh_arready <= 1'b0;
      end
      else
      begin
         ocl_sh_awready <= (slv_state_nxt == SLV_WR_ADDR);
         ocl_sh_wready  <= slv_cyc_done &&  slv_cyc_wr;
         ocl_sh_arready <= slv_cyc_done && !slv_cyc_wr;
      end

   assign ocl_sh_bvalid = (slv_state == SLV_RESP) &&  slv_cyc_wr;
   assign ocl_sh_bresp  = slv_resp;
   assign ocl_sh_rvalid = (slv_state == SLV_RESP) && !slv_cyc_wr;
   assign ocl_sh_rresp  = slv_resp;
   assign ocl_sh_rdata  = slv_rdata;

   a_b_stable: assert property (@(posedge clk) disable iff (!sync_rst_n)
      ocl_sh_bvalid && !sh_ocl_bready |=> ocl_sh_bvalid && $stable(ocl_sh_bresp));

   a_r_stable: assert property (@(posedge clk) disable iff (!sync_rst_n)
      ocl_sh_rvalid && !sh_ocl_rready |=>
         ocl_sh_rvalid && $stable(ocl_sh_rdata) && $stable(ocl_sh_rresp));

endmodule

`default_nettype wire

// ==== source/tst_cfg_block.sv ====
`timescale 1ns/1ps
`default_nettype none

module tst_cfg_block #(
   parameter int BLOCK_ID = 0
) (
   input  logic                 clk,
   input  logic                 sync_rst_n,
   input  cl_ocl_pkg::cfg_req_t req,
   output cl_ocl_pkg::cfg_rsp_t rsp
);

   import cl_ocl_pkg::*;

   logic [31:0] scratch;
   logic [31:0] wr_cnt;      // Accepted writes
   logic [1:0]  reg_idx;
   logic [31:0] rd_mux;

   assign reg_idx = req.addr[3:2];

   // ------------------------------
   // Register writes
   // ------------------------------

   always_ff @(posedge clk)
      if (!sync_rst_n)
      begin
         scratch <= '0;
         wr_cnt  <= '0;
      end
      else if (req.wr)
      begin
         wr_cnt <= wr_cnt + 32'd1;    // Any offset counts
         if (reg_idx == REG_SCRATCH)
         begin
            for (int b = 0; b < 4; b++)
               if (req.wstrb[b])
                  scratch[8*b +: 8] <= req.wdata[8*b +: 8];
         end
      end

   // ------------------------------
   // Read mux and response
   // ------------------------------

   always_comb
   begin
      case (reg_idx)
         REG_SCRATCH: rd_mux = scratch;
         REG_ID:      rd_mux = 32'(BLOCK_ID);
         REG_WR_CNT:  rd_mux = wr_cnt;
         default:     rd_mux = '0;
      endcase
   end

   // Answer one clock after the pulse
   always_ff @(posedge clk)
      if (!sync_rst_n)
         rsp <= '0;
      else
      begin
         rsp.ack   <= req.wr || req.rd;
         rsp.rdata <= req.rd ? rd_mux : '0;
      end

   a_wr_rd_excl: assert property (@(posedge clk) disable iff (!sync_rst_n)
      !(req.wr && req.rd));

endmodule

`default_nettype wire

// ==== source/cfg_rsp_collect.sv ====
`timescale 1ns/1ps
`default_nettype none

module cfg_rsp_collect #(
   parameter int NUM_TST = 4
) (
   input  logic                 clk,
   input  logic                 sync_rst_n,
   input  cl_ocl_pkg::cfg_rsp_t tst_rsp [NUM_TST],
   output cl_ocl_pkg::cfg_rsp_t done_rsp
);

   logic [NUM_TST-1:0] ack_vec;
   logic [31:0]        rdata_or;

   // Only an acking block contributes data
   always_comb
   begin
      rdata_or = '0;
      for (int i = 0; i < NUM_TST; i++)
      begin
         ack_vec[i] = tst_rsp[i].ack;
         rdata_or   = rdata_or | ({32{tst_rsp[i].ack}} & tst_rsp[i].rdata);
      end
   end

   always_ff @(posedge clk)
      if (!sync_rst_n)
         done_rsp <= '0;
      else
      begin
         done_rsp.ack   <= |ack_vec;
         done_rsp.rdata <= rdata_or;
      end

   // Slave sends one pulse to one block at a time
   a_one_ack: assert property (@(posedge clk) disable iff (!sync_rst_n)
      $onehot0(ack_vec));

endmodule

`default_nettype wire

// ==== source/cl_ocl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cl_ocl_top #(
   parameter int NUM_TST = 4
) (
   input  logic        clk,
   input  logic        sync_rst_n,

   input  logic [31:0] sh_ocl_awaddr,
   input  logic        sh_ocl_awvalid,
   output logic        ocl_sh_awready,

   input  logic [31:0] sh_ocl_wdata,
   input  logic [3:0]  sh_ocl_wstrb,
   input  logic        sh_ocl_wvalid,
   output logic        ocl_sh_wready,

   output logic [1:0]  ocl_sh_bresp,
   output logic        ocl_sh_bvalid,
   input  logic        sh_ocl_bready,

   input  logic [31:0] sh_ocl_araddr,
   input  logic        sh_ocl_arvalid,
   output logic        ocl_sh_arready,

   output logic [31:0] ocl_sh_rdata,
   output logic [1:0]  ocl_sh_rresp,
   output logic        ocl_sh_rvalid,
   input  logic        sh_ocl_rready
);

   import cl_ocl_pkg::*;

   cfg_req_t tst_req [NUM_TST];
   cfg_rsp_t tst_rsp [NUM_TST];
   cfg_rsp_t tst_done;            // Merged completion

   cl_ocl_slv #(
      .NUM_TST (NUM_TST)
   ) i_cl_ocl_slv (
      .clk            (clk),
      .sync_rst_n     (sync_rst_n),
      .sh_ocl_awaddr  (sh_ocl_awaddr),
      .sh_ocl_awvalid (sh_ocl_awvalid),
      .ocl_sh_awready (ocl_sh_awready),
      .sh_ocl_wdata   (sh_ocl_wdata),
      .sh_ocl_wstrb   (sh_ocl_wstrb),
      .sh_ocl_wvalid  (sh_ocl_wvalid),
      .ocl_sh_wready  (ocl_sh_wready),
      .ocl_sh_bresp   (ocl_sh_bresp),
      .ocl_sh_bvalid  (ocl_sh_bvalid),
      .sh_ocl_bready  (sh_ocl_bready),
      .sh_ocl_araddr  (sh_ocl_araddr),
      .sh_ocl_arvalid (sh_ocl_arvalid),
      .ocl_sh_arready (ocl_sh_arready),
      .ocl_sh_rdata   (ocl_sh_rdata),
      .ocl_sh_rresp   (ocl_sh_rresp),
      .ocl_sh_rvalid  (ocl_sh_rvalid),
      .sh_ocl_rready  (sh_ocl_rready),
      .tst_req        (tst_req),
      .tst_done       (tst_done)
   );

   // ------------------------------
   // Test blocks
   // ------------------------------

   for (genvar i = 0; i < NUM_TST; i++)
   begin : g_tst
      tst_cfg_block #(
         .BLOCK_ID (i)
      ) i_tst_cfg_block (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .req        (tst_req[i]),
         .rsp        (tst_rsp[i])
      );
   end

   cfg_rsp_collect #(
      .NUM_TST (NUM_TST)
   ) i_cfg_rsp_collect (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .tst_rsp    (tst_rsp),
      .done_rsp   (tst_done)
   );

endmodule

`default_nettype wire

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
   parameter real PERIOD_NS = 10.0
) (
   output logic clk
);

   initial
   begin
      clk = 1'b0;
      forever
         #(PERIOD_NS / 2.0) clk = ~clk;
   end

endmodule

`default_nettype wire

// ==== testbench/tb_cl_ocl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cl_ocl_top;

   import cl_ocl_pkg::*;

   localparam int NUM_TST     = 4;
   localparam int NUM_XACT    = 100;           // Transactions issued by all tests
   localparam int WDOG_CYCLES = NUM_XACT * 50;

   logic        clk;
   logic        sync_rst_n;
   logic [31:0] sh_ocl_awaddr;
   logic        sh_ocl_awvalid;
   logic        ocl_sh_awready;
   logic [31:0] sh_ocl_wdata;
   logic [3:0]  sh_ocl_wstrb;
   logic        sh_ocl_wvalid;
   logic        ocl_sh_wready;
   logic [1:0]  ocl_sh_bresp;
   logic        ocl_sh_bvalid;
   logic        sh_ocl_bready;
   logic [31:0] sh_ocl_araddr;
   logic        sh_ocl_arvalid;
   logic        ocl_sh_arready;
   logic [31:0] ocl_sh_rdata;
   logic [1:0]  ocl_sh_rresp;
   logic        ocl_sh_rvalid;
   logic        sh_ocl_rready;

   logic [15:0] lfsr;
   logic        bp_en;                         // Random ready back-pressure
   int          error_count;
   logic [31:0] scratch_model [NUM_TST];
   int          wr_cnt_model [NUM_TST];
   logic [7:0]  sel;
   logic [1:0]  idx;
   logic [31:0] data;
   logic [3:0]  strb;

   tb_clk_gen #(.PERIOD_NS (10.0)) i_tb_clk_gen (.clk (clk));

   cl_ocl_top #(
      .NUM_TST (NUM_TST)
   ) i_cl_ocl_top (
      .clk            (clk),
      .sync_rst_n     (sync_rst_n),
      .sh_ocl_awaddr  (sh_ocl_awaddr),
      .sh_ocl_awvalid (sh_ocl_awvalid),
      .ocl_sh_awready (ocl_sh_awready),
      .sh_ocl_wdata   (sh_ocl_wdata),
      .sh_ocl_wstrb   (sh_ocl_wstrb),
      .sh_ocl_wvalid  (sh_ocl_wvalid),
      .ocl_sh_wready  (ocl_sh_wready),
      .ocl_sh_bresp   (ocl_sh_bresp),
      .ocl_sh_bvalid  (ocl_sh_bvalid),
      .sh_ocl_bready  (sh_ocl_bready),
      .sh_ocl_araddr  (sh_ocl_araddr),
      .sh_ocl_arvalid (sh_ocl_arvalid),
      .ocl_sh_arready (ocl_sh_arready),
      .ocl_sh_rdata   (ocl_sh_rdata),
      .ocl_sh_rresp   (ocl_sh_rresp),
      .ocl_sh_rvalid  (ocl_sh_rvalid),
      .sh_ocl_rready  (sh_ocl_rready)
   );

   // ------------------------------
   // Helpers
   // ------------------------------

   task report_error(input string msg);
      error_count++;
      $display("ERR @%0t: %s", $time, msg);
      $display("Finished with errors");
      $fatal(1);
   endtask

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] val;
      logic        fb;
      val = '0;
      for (int i = 0; i < n; i++)
      begin
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         val  = {val[30:0], fb};
      end
      return val;
   endfunction

   function automatic logic pick_ready();
      if (bp_en)
         return (take_bits(1) != 0);
      return 1'b1;
   endfunction

   function automatic logic [31:0] make_addr(input logic [7:0] s, input logic [1:0] r);
      return {16'h0, s, 4'h0, r, 2'b00};
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] nw,
                                                input logic [3:0] be);
      logic [31:0] res;
      res = old;
      for (int b = 0; b < 4; b++)
         if (be[b])
            res[8*b +: 8] = nw[8*b +: 8];
      return res;
   endfunction

   function automatic logic [31:0] expected_rdata(input logic [7:0] s, input logic [1:0] r);
      if (s >= NUM_TST)
         return '0;
      case (r)
         REG_SCRATCH: return scratch_model[s];
         REG_ID:      return 32'(s);
         REG_WR_CNT:  return 32'(wr_cnt_model[s]);
         default:     return '0;
      endcase
   endfunction

   task automatic model_write(input logic [7:0] s, input logic [1:0] r, input logic [31:0] d,
                              input logic [3:0] be);
      wr_cnt_model[s]++;
      if (r == REG_SCRATCH)
         scratch_model[s] = merge_bytes(scratch_model[s], d, be);
   endtask

   // ------------------------------
   // AXI-Lite host
   // ------------------------------

   // Outputs are registered, so they are stable at the falling edge
   task automatic run_xact(input logic do_wr, input logic [31:0] wr_addr,
                           input logic [31:0] wr_data, input logic [3:0] wr_strb,
                           input logic do_rd, input logic [31:0] rd_addr,
                           output logic [1:0] b_resp, output logic [1:0] r_resp,
                           output logic [31:0] r_data, output int b_cyc, output int r_cyc);
      logic b_pend;
      logic r_pend;
      logic hs_aw, hs_w, hs_ar, hs_b, hs_r;
      int   cyc;
      b_resp = '0;
      r_resp = '0;
      r_data = '0;
      b_cyc  = -1;
      r_cyc  = -1;
      cyc    = 0;
      @(negedge clk);
      sh_ocl_awaddr  = wr_addr;
      sh_ocl_awvalid = do_wr;
      sh_ocl_wdata   = wr_data;
      sh_ocl_wstrb   = wr_strb;
      sh_ocl_wvalid  = do_wr;
      sh_ocl_araddr  = rd_addr;
      sh_ocl_arvalid = do_rd;
      sh_ocl_bready  = pick_ready();
      sh_ocl_rready  = pick_ready();
      b_pend = do_wr;
      r_pend = do_rd;
      while (b_pend || r_pend)
      begin
         hs_aw = sh_ocl_awvalid && ocl_sh_awready;
         hs_w  = sh_ocl_wvalid && ocl_sh_wready;
         hs_ar = sh_ocl_arvalid && ocl_sh_arready;
         hs_b  = ocl_sh_bvalid && sh_ocl_bready;
         hs_r  = ocl_sh_rvalid && sh_ocl_rready;
         if (hs_b)
         begin
            b_resp = ocl_sh_bresp;
            b_cyc  = cyc;
         end
         if (hs_r)
         begin
            r_resp = ocl_sh_rresp;
            r_data = ocl_sh_rdata;
            r_cyc  = cyc;
         end
         @(negedge clk);
         cyc++;
         if (hs_aw) sh_ocl_awvalid = 1'b0;
         if (hs_w)  sh_ocl_wvalid  = 1'b0;
         if (hs_ar) sh_ocl_arvalid = 1'b0;
         if (hs_b)  b_pend = 1'b0;
         if (hs_r)  r_pend = 1'b0;
         sh_ocl_bready = pick_ready();
         sh_ocl_rready = pick_ready();
      end
      assert (!sh_ocl_awvalid && !sh_ocl_wvalid && !sh_ocl_arvalid)
         else report_error("address or write data not accepted by the end of the transaction");
   endtask

   task automatic write_reg(input logic [7:0] s, input logic [1:0] r,
                            input logic [31:0] d, input logic [3:0] be);
      logic [1:0]  b_resp, r_resp, exp_resp;
      logic [31:0] r_data;
      int          b_cyc, r_cyc;
      run_xact(1'b1, make_addr(s, r), d, be, 1'b0, '0, b_resp, r_resp, r_data, b_cyc, r_cyc);
      exp_resp = RESP_DECERR;
      if (s < NUM_TST)
      begin
         exp_resp = RESP_OKAY;
         model_write(s, r, d, be);
      end
      assert (b_resp == exp_resp)
         else report_error($sformatf("write sel %0d bresp %0d, expected %0d", s, b_resp, exp_resp));
   endtask

   task automatic read_reg(input logic [7:0] s, input logic [1:0] r);
      logic [1:0]  b_resp, r_resp, exp_resp;
      logic [31:0] r_data, exp_data;
      int          b_cyc, r_cyc;
      run_xact(1'b0, '0, '0, '0, 1'b1, make_addr(s, r), b_resp, r_resp, r_data, b_cyc, r_cyc);
      exp_resp = (s < NUM_TST) ? RESP_OKAY : RESP_DECERR;
      exp_data = expected_rdata(s, r);
      assert (r_resp == exp_resp)
         else report_error($sformatf("read sel %0d rresp %0d, expected %0d", s, r_resp, exp_resp));
      assert (r_data == exp_data)
         else report_error($sformatf("read sel %0d reg %0d got %08h, expected %08h",
                                     s, r, r_data, exp_data));
   endtask

   // Write and read of one scratch register presented together
   task automatic paired_wr_rd(input logic [7:0] s, input logic [31:0] d, input logic [3:0] be);
      logic [1:0]  b_resp, r_resp;
      logic [31:0] r_data;
      int          b_cyc, r_cyc;
      run_xact(1'b1, make_addr(s, REG_SCRATCH), d, be, 1'b1, make_addr(s, REG_SCRATCH),
               b_resp, r_resp, r_data, b_cyc, r_cyc);
      model_write(s, REG_SCRATCH, d, be);
      assert (b_resp == RESP_OKAY && r_resp == RESP_OKAY)
         else report_error($sformatf("pair bresp %0d rresp %0d, expected OKAY", b_resp, r_resp));
      assert (r_data == scratch_model[s])
         else report_error($sformatf("pair read %08h, expected %08h", r_data, scratch_model[s]));
      assert (b_cyc < r_cyc)
         else report_error($sformatf("read done at cycle %0d before write at %0d", r_cyc, b_cyc));
   endtask

   // ------------------------------
   // Protocol checks
   // ------------------------------

   a_resp_excl: assert property (@(posedge clk) disable iff (!sync_rst_n)
      !(ocl_sh_bvalid && ocl_sh_rvalid))
      else report_error("bvalid and rvalid high together");

   a_b_hold: assert property (@(posedge clk) disable iff (!sync_rst_n)
      ocl_sh_bvalid && !sh_ocl_bready |=> ocl_sh_bvalid && $stable(ocl_sh_bresp))
      else report_error("bvalid or bresp changed while bready low");

   a_r_hold: assert property (@(posedge clk) disable iff (!sync_rst_n)
      ocl_sh_rvalid && !sh_ocl_rready |=>
         ocl_sh_rvalid && $stable(ocl_sh_rdata) && $stable(ocl_sh_rresp))
      else report_error("rvalid or read payload changed while rready low");

   // Pending read of a pair waits behind the write response
   a_no_new_xact: assert property (@(posedge clk) disable iff (!sync_rst_n)
      ocl_sh_bvalid |-> !ocl_sh_arready)
      else report_error("read address accepted during a write response");

   initial
   begin
      repeat (WDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired before all tests completed");
      $display("Finished with errors");
      $fatal(1);
   end

   // ------------------------------
   // Test sequence
   // ------------------------------

   initial
   begin
      lfsr           = 16'd23;
      bp_en          = 1'b0;
      error_count    = 0;
      sync_rst_n     = 1'b0;
      sh_ocl_awaddr  = '0;
      sh_ocl_awvalid = 1'b0;
      sh_ocl_wdata   = '0;
      sh_ocl_wstrb   = '0;
      sh_ocl_wvalid  = 1'b0;
      sh_ocl_bready  = 1'b0;
      sh_ocl_araddr  = '0;
      sh_ocl_arvalid = 1'b0;
      sh_ocl_rready  = 1'b0;
      for (int i = 0; i < NUM_TST; i++)
      begin
         scratch_model[i] = '0;
         wr_cnt_model[i]  = 0;
      end
      repeat (4) @(posedge clk);
      @(negedge clk);
      sync_rst_n = 1'b1;

      assert (!ocl_sh_awready && !ocl_sh_wready && !ocl_sh_arready &&
              !ocl_sh_bvalid && !ocl_sh_rvalid)
         else report_error("handshake outputs not low after reset");

      // Random scratch writes with read-back
      for (int i = 0; i < 24; i++)
      begin
         sel  = 8'(take_bits(2));
         data = take_bits(32);
         strb = 4'(take_bits(4));
         write_reg(sel, REG_SCRATCH, data, strb);
         read_reg(sel, REG_SCRATCH);
      end
      for (int i = 0; i < 4; i++)
      begin
         idx = 2'(take_bits(2)) | 2'd1;  // Read-only offsets
         write_reg(8'(i), idx, take_bits(32), 4'hf);
      end
      for (int i = 0; i < NUM_TST; i++)
         read_reg(8'(i), REG_SCRATCH);

      // Identity, counters and the unused offset
      for (int i = 0; i < NUM_TST; i++)
      begin
         read_reg(8'(i), REG_ID);
         read_reg(8'(i), REG_WR_CNT);
         read_reg(8'(i), 2'd3);
      end

      // Unmapped selects
      sel = 8'(NUM_TST) + 8'(take_bits(7));
      write_reg(sel, REG_SCRATCH, take_bits(32), 4'hf);
      read_reg(sel, REG_SCRATCH);
      write_reg(8'hff, REG_WR_CNT, take_bits(32), 4'hf);
      read_reg(8'hff, REG_ID);
      for (int i = 0; i < NUM_TST; i++)
         read_reg(8'(i), REG_WR_CNT);

      // Back-pressure on B and R
      bp_en = 1'b1;
      for (int i = 0; i < 8; i++)
      begin
         sel  = 8'(take_bits(2));
         data = take_bits(32);
         strb = 4'(take_bits(4));
         write_reg(sel, REG_SCRATCH, data, strb);
         read_reg(sel, REG_SCRATCH);
      end

      // Write and read arriving together
      for (int i = 0; i < 4; i++)
      begin
         sel  = 8'(take_bits(2));
         data = take_bits(32);
         strb = 4'(take_bits(4));
         paired_wr_rd(sel, data, strb);
      end

      repeat (2) @(negedge clk);
      if (error_count == 0)
         $display("Finished with no errors");
      else
         $display("Finished with errors");
      $finish;
   end

endmodule

`default_nettype wire

// ==== flist.f ====
source/cl_ocl_pkg.sv
source/cl_ocl_slv.sv
source/tst_cfg_block.sv
source/cfg_rsp_collect.sv
source/cl_ocl_top.sv
testbench/tb_clk_gen.sv
testbench/tb_cl_ocl_top.sv

// ==== Bender.yml ====
package:
  name: cl_ocl

sources:
  - files:
      - source/cl_ocl_pkg.sv
      - source/cl_ocl_slv.sv
      - source/tst_cfg_block.sv
      - source/cfg_rsp_collect.sv
      - source/cl_ocl_top.sv

  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_cl_ocl_top.sv
